//--- design/fetch_pkg.sv
package fetch_pkg;

  // instruction word width
  localparam int INSN_W = 32;

  // A64 HLT #0, sent downstream when the pc reaches zero
  localparam logic [INSN_W-1:0] INSNBITS_HLT = 32'hd440_0000;

  // opcodes the front end has to tell apart
  typedef enum logic [2:0] {
    OP_B,
    OP_BL,
    OP_RET,
    OP_HLT,
    OP_NOP,
    OP_OTHER
  } opcode_t;

  // packet handed to decode
  typedef struct packed {
    logic              valid;
    logic [63:0]       pc;
    logic [INSN_W-1:0] insnbits;
  } fetch_pkt_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [63:0]       adr;
    logic [INSN_W-1:0] dat_w;
  } wb_req_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic              ack;
    logic [INSN_W-1:0] dat_r;
  } wb_rsp_t;

endpackage

//--- design/insn_predecoder.sv
`timescale 1ns/100ps

module insn_predecoder
  import fetch_pkg::*;
(
  input  logic [INSN_W-1:0]  insnbits,
  output opcode_t            opcode,
  output logic signed [63:0] imm
);

  // unconditional immediate branches, top six bits
  localparam logic [5:0] B_TOP  = 6'b000101;
  localparam logic [5:0] BL_TOP = 6'b100101;

  // RET, any Rn
  localparam logic [31:0] RET_MASK  = 32'hffff_fc1f;
  localparam logic [31:0] RET_MATCH = 32'hd65f_0000;

  // HLT, any 16-bit immediate
  localparam logic [31:0] HLT_MASK  = 32'hffe0_001f;
  localparam logic [31:0] HLT_MATCH = 32'hd440_0000;

  // the one hint encoding fetch cares about
  localparam logic [31:0] NOP_WORD = 32'hd503_201f;

  logic        is_b;
  logic        is_bl;
  logic        is_ret;
  logic        is_hlt;
  logic        is_nop;
  logic [63:0] branch_off;

  always_comb begin
    is_b   = (insnbits[31:26] == B_TOP);
    is_bl  = (insnbits[31:26] == BL_TOP);
    is_ret = ((insnbits & RET_MASK) == RET_MATCH);
    is_hlt = ((insnbits & HLT_MASK) == HLT_MATCH);
    is_nop = (insnbits == NOP_WORD);
  end

  always_comb begin
    if (is_b) begin
      opcode = OP_B;
    end else if (is_bl) begin
      opcode = OP_BL;
    end else if (is_ret) begin
      opcode = OP_RET;
    end else if (is_hlt) begin
      opcode = OP_HLT;
    end else if (is_nop) begin
      opcode = OP_NOP;
    end else begin
      opcode = OP_OTHER;
    end
  end

  // imm26 is a word offset
  // scale by 4 and sign extend to the pc width
  always_comb begin
    branch_off = {{36{insnbits[25]}}, insnbits[25:0], 2'b00};
  end

  always_comb begin
    if (is_b || is_bl) begin
      imm = branch_off;
    end else begin
      imm = '0;
    end
  end

endmodule

//--- design/imem_wb.sv
`timescale 1ns/100ps

module imem_wb
  import fetch_pkg::*;
#(
  parameter int MEM_BYTES = 4096
) (
  input  logic    in_clk,
  input  logic    in_rst,
  input  wb_req_t load_req,
  output wb_rsp_t load_rsp,
  input  wb_req_t fetch_req,
  output wb_rsp_t fetch_rsp
);

  localparam int AW = $clog2(MEM_BYTES);

  // byte wide storage, words are little endian
  logic [7:0] mem [MEM_BYTES];

  // word index, address taken modulo MEM_BYTES
  logic [AW-3:0] load_widx;
  logic [AW-3:0] fetch_widx;

  logic              load_hit;
  logic              fetch_hit;
  logic              load_ack;
  logic              fetch_ack;
  logic [INSN_W-1:0] load_word;
  logic [INSN_W-1:0] fetch_word;
  logic [INSN_W-1:0] load_data;
  logic [INSN_W-1:0] fetch_data;

  always_comb begin
    load_widx  = load_req.adr[AW-1:2];
    fetch_widx = fetch_req.adr[AW-1:2];
    // a strobe that was already acked last cycle is a finished access
    load_hit   = load_req.cyc & load_req.stb & ~load_ack;
    fetch_hit  = fetch_req.cyc & fetch_req.stb & ~fetch_ack;
  end

  // gather the addressed bytes for each port
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      load_word[8*i +: 8]  = mem[{load_widx, 2'(i)}];
      fetch_word[8*i +: 8] = mem[{fetch_widx, 2'(i)}];
    end
  end

  // load port stays live while in_rst is high
  // programs are written while fetch sits in reset
  always_ff @(posedge in_clk) begin
    load_ack <= load_hit;
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      fetch_ack <= 1'b0;
    end else begin
      fetch_ack <= fetch_hit;
    end
  end

  // write lands on the edge that raises ack
  always_ff @(posedge in_clk) begin
    if (load_hit && load_req.we) begin
      for (int i = 0; i < 4; i++) begin
        mem[{load_widx, 2'(i)}] <= load_req.dat_w[8*i +: 8];
      end
    end
  end

  // registered read data, valid in the ack cycle
  always_ff @(posedge in_clk) begin
    if (load_hit) begin
      load_data <= load_word;
    end
    if (fetch_hit) begin
      fetch_data <= fetch_word;
    end
  end

  always_comb begin
    load_rsp.ack    = load_ack;
    load_rsp.dat_r  = load_data;
    fetch_rsp.ack   = fetch_ack;
    fetch_rsp.dat_r = fetch_data;
  end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
  import fetch_pkg::*;
#(
  parameter logic [63:0] ENTRY_PC = 64'h0000_0000_0000_0400
) (
  input  logic               in_clk,
  input  logic               in_rst,
  input  logic               rob_mispredict,
  input  logic [63:0]        rob_new_pc,
  input  logic               decode_stall,
  output wb_req_t            mem_req,
  input  wb_rsp_t            mem_rsp,
  output logic [INSN_W-1:0]  word,
  input  opcode_t            opcode,
  input  logic signed [63:0] imm,
  output fetch_pkt_t         d_pkt,
  output logic               halt
);

  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT_ACK,
    HOLD,
    HALTED
  } state_t;

  state_t            state;
  logic [63:0]       pc;
  logic              pkt_valid;
  logic [63:0]       pkt_pc;
  logic [INSN_W-1:0] pkt_insn;

  logic              out_free;
  logic              pc_zero;
  logic              issue;
  logic              got_ack;
  logic              load_word;
  logic              load_halt;
  logic              is_branch;
  logic [63:0]       next_pc;

  always_comb begin
    // output register is empty or drains at this edge
    out_free  = ~pkt_valid | ~decode_stall;
    pc_zero   = (pc == 64'd0);
    issue     = (state == REQ) & out_free & ~pc_zero & ~rob_mispredict;
    got_ack   = (state == WAIT_ACK) & mem_rsp.ack & ~rob_mispredict;
    // an all zero word is dropped and the same pc is read again
    load_word = got_ack & (mem_rsp.dat_r != '0);
    load_halt = (state == REQ) & out_free & pc_zero & ~rob_mispredict;
    is_branch = (opcode == OP_B) | (opcode == OP_BL);
    next_pc   = is_branch ? pc + $unsigned(imm) : pc + 64'd4;
  end

  // read only master, cyc held through the ack cycle
  always_comb begin
    mem_req.cyc   = issue | (state == WAIT_ACK);
    mem_req.stb   = issue | (state == WAIT_ACK);
    mem_req.we    = 1'b0;
    mem_req.adr   = pc;
    mem_req.dat_w = '0;
  end

  assign word = mem_rsp.dat_r;

  assign d_pkt = '{valid: pkt_valid, pc: pkt_pc, insnbits: pkt_insn};

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state     <= IDLE;
      pc        <= ENTRY_PC;
      pkt_valid <= 1'b0;
      halt      <= 1'b0;
    end else if (rob_mispredict) begin
      // redirect wins over stall and kills the access in flight
      state     <= REQ;
      pc        <= rob_new_pc;
      pkt_valid <= 1'b0;
      halt      <= 1'b0;
    end else begin
      if (pkt_valid && !decode_stall) begin
        pkt_valid <= 1'b0;
      end
      case (state)
        IDLE: begin
          state <= REQ;
        end
        REQ: begin
          if (!out_free) begin
            state <= HOLD;
          end else if (pc_zero) begin
            pkt_valid <= 1'b1;
            state     <= HALTED;
          end else begin
            state <= WAIT_ACK;
          end
        end
        WAIT_ACK: begin
          if (mem_rsp.ack) begin
            if (load_word) begin
              pkt_valid <= 1'b1;
              pc        <= next_pc;
            end
            state <= REQ;
          end
        end
        HOLD: begin
          if (!decode_stall) begin
            state <= REQ;
          end
        end
        HALTED: begin
          // halt follows the HLT packet by one cycle
          halt <= 1'b1;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // packet payload, qualified by pkt_valid
  always_ff @(posedge in_clk) begin
    if (load_word || load_halt) begin
      pkt_pc   <= pc;
      pkt_insn <= load_halt ? INSNBITS_HLT : mem_rsp.dat_r;
    end
  end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
  import fetch_pkg::*;
#(
  parameter int          MEM_BYTES = 4096,
  parameter logic [63:0] ENTRY_PC  = 64'h0000_0000_0000_0400
) (
  input  logic        in_clk,
  input  logic        in_rst,
  input  logic        rob_mispredict,
  input  logic [63:0] rob_new_pc,
  input  logic        decode_stall,
  input  wb_req_t     load_req,
  output wb_rsp_t     load_rsp,
  output fetch_pkt_t  d_pkt,
  output logic        halt
);

  wb_req_t            fetch_req;
  wb_rsp_t            fetch_rsp;
  logic [INSN_W-1:0]  word;
  opcode_t            opcode;
  logic signed [63:0] imm;

  fetch_unit #(
    .ENTRY_PC(ENTRY_PC)
  ) fetch_unit_i (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .rob_mispredict(rob_mispredict),
    .rob_new_pc    (rob_new_pc),
    .decode_stall  (decode_stall),
    .mem_req       (fetch_req),
    .mem_rsp       (fetch_rsp),
    .word          (word),
    .opcode        (opcode),
    .imm           (imm),
    .d_pkt         (d_pkt),
    .halt          (halt)
  );

  insn_predecoder insn_predecoder_i (
    .insnbits(word),
    .opcode  (opcode),
    .imm     (imm)
  );

  imem_wb #(
    .MEM_BYTES(MEM_BYTES)
  ) imem_wb_i (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .load_req (load_req),
    .load_rsp (load_rsp),
    .fetch_req(fetch_req),
    .fetch_rsp(fetch_rsp)
  );

endmodule

//--- verification/fetch_assertions.sv
`timescale 1ns/100ps

module fetch_assertions
  import fetch_pkg::*;
(
  input logic        in_clk,
  input logic        in_rst,
  input logic        rob_mispredict,
  input logic [63:0] rob_new_pc,
  input logic        decode_stall,
  input fetch_pkt_t  d_pkt,
  input logic        halt
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  logic              consumed;
  logic              have_prev;
  logic              redirected;
  logic [63:0]       prev_pc;
  logic [INSN_W-1:0] prev_insn;
  logic              redirect_open;
  logic [63:0]       redirect_pc;

  // B and BL jump by the scaled imm26
  // anything else steps one word
  function automatic logic [63:0] follow_pc(input logic [63:0] pc, input logic [31:0] insn);
    if (insn[30:26] == 5'b00101) begin
      return pc + {{36{insn[25]}}, insn[25:0], 2'b00};
    end
    return pc + 64'd4;
  endfunction

  assign consumed = d_pkt.valid & ~decode_stall & ~in_rst;

  // last consumed packet and whether a redirect came after it
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      have_prev     <= 1'b0;
      redirected    <= 1'b0;
      redirect_open <= 1'b0;
    end else begin
      if (consumed) begin
        prev_pc    <= d_pkt.pc;
        prev_insn  <= d_pkt.insnbits;
        have_prev  <= 1'b1;
        redirected <= rob_mispredict;
      end else if (rob_mispredict) begin
        redirected <= 1'b1;
      end
      if (rob_mispredict) begin
        redirect_open <= 1'b1;
        redirect_pc   <= rob_new_pc;
      end else if (d_pkt.valid) begin
        redirect_open <= 1'b0;
      end
    end
  end

  // covers every reset cycle and the first cycle after release
  reset_quiet: assert property (@(posedge in_clk)
    (in_rst || $past(in_rst)) |=> (!d_pkt.valid && !halt))
    else begin
      $error("CHECK FAILED at %0d ns: valid or halt high in reset or the cycle after it",
             $time);
      fail_count++;
    end

  stall_hold: assert property (@(posedge in_clk) disable iff (in_rst)
    (d_pkt.valid && decode_stall && !rob_mispredict) |=> $stable(d_pkt))
    else begin
      $error("CHECK FAILED at %0d ns: held packet changed under decode_stall", $time);
      fail_count++;
    end

  next_pc_rule: assert property (@(posedge in_clk) disable iff (in_rst)
    (consumed && have_prev && !redirected) |-> (d_pkt.pc == follow_pc(prev_pc, prev_insn)))
    else begin
      $error("CHECK FAILED at %0d ns: packet pc %h does not follow pc %h",
             $time, d_pkt.pc, prev_pc);
      fail_count++;
    end

  redirect_target: assert property (@(posedge in_clk) disable iff (in_rst)
    (d_pkt.valid && redirect_open) |-> (d_pkt.pc == redirect_pc))
    else begin
      $error("CHECK FAILED at %0d ns: first packet after redirect has pc %h, not %h",
             $time, d_pkt.pc, redirect_pc);
      fail_count++;
    end

  halt_after_hlt: assert property (@(posedge in_clk) disable iff (in_rst)
    $rose(halt) |-> $past(d_pkt.valid && d_pkt.pc == 64'd0 && d_pkt.insnbits == INSNBITS_HLT))
    else begin
      $error("CHECK FAILED at %0d ns: halt rose without a preceding HLT packet at pc 0",
             $time);
      fail_count++;
    end

endmodule

bind fetch_top fetch_assertions fetch_assertions_i (
  .in_clk        (in_clk),
  .in_rst        (in_rst),
  .rob_mispredict(rob_mispredict),
  .rob_new_pc    (rob_new_pc),
  .decode_stall  (decode_stall),
  .d_pkt         (d_pkt),
  .halt          (halt)
);

//--- verification/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb
  import fetch_pkg::*;
();

  localparam int          MEM_BYTES = 4096;
  localparam int          AW        = $clog2(MEM_BYTES);
  localparam logic [63:0] ENTRY_PC  = 64'h0000_0000_0000_0400;
  localparam logic [15:0] LFSR_SEED = 16'd28503;
  localparam int          T4_CYCLES = 150;

  // rough cycle length of each test
  localparam int T1_LEN = 130;
  localparam int T2_LEN = 100;
  localparam int T3_LEN = 200;
  localparam int T4_LEN = 220;
  localparam int T5_LEN = 120;
  localparam int TIMEOUT_CYCLES = 2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

  logic        in_clk;
  logic        in_rst;
  logic        rob_mispredict;
  logic [63:0] rob_new_pc;
  logic        decode_stall;
  wb_req_t     load_req;
  wb_rsp_t     load_rsp;
  fetch_pkt_t  d_pkt;
  logic        halt;

  // shadow copy of every word written to the memory
  logic [31:0] shadow [MEM_BYTES/4];
  bit          written [MEM_BYTES/4];

  logic [15:0] lfsr_q;
  logic [63:0] exp_pc;
  int          pkt_count = 0;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          err_mark;
  int          pkt_mark;
  int          cycle_count;

  fetch_top #(
    .MEM_BYTES(MEM_BYTES),
    .ENTRY_PC (ENTRY_PC)
  ) fetch_top_i (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .rob_mispredict(rob_mispredict),
    .rob_new_pc    (rob_new_pc),
    .decode_stall  (decode_stall),
    .load_req      (load_req),
    .load_rsp      (load_rsp),
    .d_pkt         (d_pkt),
    .halt          (halt)
  );

  initial in_clk = 1'b0;
  always #10 in_clk = ~in_clk;

  // fibonacci lfsr with taps 16 14 13 11
  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] filler_word();
    logic [31:0] w;
    w = take_bits(32);
    // steer away from the B and BL major opcode
    if (w[30:26] == 5'b00101) w[27] = 1'b1;
    if (w == '0) w = 32'hd503_201f;
    return w;
  endfunction

  function automatic logic [31:0] branch_word(input logic link, input logic [63:0] from,
                                              input logic [63:0] to);
    logic [63:0] delta;
    delta = to - from;
    return {link, 5'b00101, delta[27:2]};
  endfunction

  function automatic logic [63:0] rule_next_pc(input logic [63:0] pc, input logic [31:0] insn);
    if (insn[30:26] == 5'b00101) begin
      return pc + {{36{insn[25]}}, insn[25:0], 2'b00};
    end
    return pc + 64'd4;
  endfunction

  function automatic int error_total();
    return tb_errors + fetch_top_i.fetch_assertions_i.fail_count;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    tb_errors++;
  endtask

  task automatic check_packet(input logic [63:0] pc, input logic [31:0] insn);
    logic [31:0] expect_insn;
    pkt_count++;
    expect_insn = shadow[pc[AW-1:2]];
    if (pc == 64'd0) expect_insn = INSNBITS_HLT;
    if (pc != exp_pc) report_mismatch($sformatf("packet pc %h, expected %h", pc, exp_pc));
    if (pc != 64'd0 && !written[pc[AW-1:2]]) begin
      report_mismatch($sformatf("packet from unwritten address %h", pc));
    end else if (insn != expect_insn || insn == '0) begin
      report_mismatch($sformatf("pc %h bits %h, expected %h", pc, insn, expect_insn));
    end
    exp_pc = rule_next_pc(pc, insn);
  endtask

  // consumption happens on an edge with valid high and stall low
  always @(posedge in_clk) begin
    if (in_rst) begin
      exp_pc = ENTRY_PC;
    end else begin
      if (d_pkt.valid && !decode_stall) check_packet(d_pkt.pc, d_pkt.insnbits);
      if (rob_mispredict) exp_pc = rob_new_pc;
    end
  end

  task automatic write_imem(input logic [63:0] addr, input logic [31:0] data);
    @(negedge in_clk);
    load_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat_w: data};
    do @(negedge in_clk); while (!load_rsp.ack);
    load_req = '0;
    shadow[addr[AW-1:2]]  = data;
    written[addr[AW-1:2]] = 1'b1;
  endtask

  // read a word through the load port and compare it with the shadow copy
  task automatic read_back(input logic [63:0] addr);
    @(negedge in_clk);
    load_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat_w: 32'd0};
    do @(negedge in_clk); while (!load_rsp.ack);
    load_req = '0;
    if (load_rsp.dat_r !== shadow[addr[AW-1:2]]) begin
      report_mismatch($sformatf("load port read %h at %h, expected %h",
                                load_rsp.dat_r, addr, shadow[addr[AW-1:2]]));
    end
  endtask

  task automatic begin_load();
    @(negedge in_clk);
    in_rst         = 1'b1;
    rob_mispredict = 1'b0;
    decode_stall   = 1'b0;
  endtask

  task automatic end_load();
    repeat (8) @(negedge in_clk);
    in_rst = 1'b0;
  endtask

  task automatic wait_packets(input int n);
    int target;
    target = pkt_count + n;
    while (pkt_count < target) @(negedge in_clk);
  endtask

  task automatic redirect(input logic [63:0] target);
    @(negedge in_clk);
    rob_mispredict = 1'b1;
    rob_new_pc     = target;
    @(negedge in_clk);
    rob_mispredict = 1'b0;
  endtask

  task automatic start_test();
    err_mark = error_total();
    pkt_mark = pkt_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d packets, %0d errors", tests_run, name, pkt_count - pkt_mark,
             error_total() - err_mark);
  endtask

  task automatic fetch_in_order();
    start_test();
    begin_load();
    for (int i = 0; i < 12; i++) write_imem(ENTRY_PC + 4 * i, filler_word());
    write_imem(ENTRY_PC + 48, branch_word(1'b0, ENTRY_PC + 48, ENTRY_PC));
    for (int i = 0; i < 13; i++) read_back(ENTRY_PC + 4 * i);
    end_load();
    wait_packets(16);
    finish_test("sequential fetch");
  endtask

  task automatic follow_branches();
    start_test();
    begin_load();
    write_imem(ENTRY_PC, filler_word());
    write_imem(ENTRY_PC + 4, branch_word(1'b0, ENTRY_PC + 4, 64'h604));
    write_imem(64'h604, filler_word());
    write_imem(64'h608, branch_word(1'b1, 64'h608, 64'h708));
    write_imem(64'h708, filler_word());
    write_imem(64'h70c, branch_word(1'b0, 64'h70c, ENTRY_PC + 8));
    write_imem(ENTRY_PC + 8, filler_word());
    write_imem(ENTRY_PC + 12, branch_word(1'b1, ENTRY_PC + 12, ENTRY_PC));
    end_load();
    wait_packets(20);
    finish_test("branches");
  endtask

  task automatic apply_backpressure();
    start_test();
    begin_load();
    end_load();
    while (pkt_count < pkt_mark + 30) begin
      @(negedge in_clk);
      decode_stall = (take_bits(1) != 0);
    end
    decode_stall = 1'b0;
    finish_test("back-pressure");
  endtask

  task automatic inject_mispredicts();
    start_test();
    begin_load();
    for (int i = 0; i < 16; i++) write_imem(64'h800 + 4 * i, filler_word());
    write_imem(64'h840, branch_word(1'b0, 64'h840, 64'h800));
    end_load();
    repeat (T4_CYCLES) begin
      @(negedge in_clk);
      decode_stall   = (take_bits(1) != 0);
      rob_mispredict = (take_bits(3) == 0);
      if (rob_mispredict) rob_new_pc = 64'h800 + 4 * take_bits(4);
    end
    @(negedge in_clk);
    rob_mispredict = 1'b0;
    decode_stall   = 1'b0;
    finish_test("mispredict");
  endtask

  task automatic halt_and_zero_word();
    int mark;
    start_test();
    begin_load();
    write_imem(64'ha00, filler_word());
    write_imem(64'ha04, filler_word());
    write_imem(64'ha08, branch_word(1'b0, 64'ha08, 64'd0));
    write_imem(64'hb00, 32'd0);
    end_load();
    redirect(64'ha00);
    while (!halt) @(negedge in_clk);
    mark = pkt_count;
    repeat (10) @(negedge in_clk);
    if (pkt_count != mark || !halt) report_mismatch("fetch did not stay halted");
    // the zero word at 0xb00 is read again and again
    redirect(64'hb00);
    repeat (20) @(negedge in_clk);
    if (pkt_count != mark) report_mismatch("zero word produced a packet");
    if (halt) report_mismatch("halt still high after redirect");
    redirect(64'ha00);
    wait_packets(2);
    finish_test("halt and empty word");
  endtask

  initial begin
    int total;
    in_rst         = 1'b1;
    rob_mispredict = 1'b0;
    rob_new_pc     = '0;
    decode_stall   = 1'b0;
    load_req       = '0;
    lfsr_q         = LFSR_SEED;
    fetch_in_order();
    follow_branches();
    apply_backpressure();
    inject_mispredicts();
    halt_and_zero_word();
    repeat (4) @(negedge in_clk);
    total = error_total();
    $display("summary: %0d tests, %0d packets checked, %0d errors", tests_run, pkt_count, total);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge in_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- project.f
design/fetch_pkg.sv
design/insn_predecoder.sv
design/imem_wb.sv
design/fetch_unit.sv
design/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv
